// ==== Makefile ====
SOURCES := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: all run clean

all: obj_dir/Vrv32_core_tb

obj_dir/Vrv32_core_tb: filelist.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ns --top-module rv32_core_tb \
		-f filelist.f -o Vrv32_core_tb

run: obj_dir/Vrv32_core_tb
	./obj_dir/Vrv32_core_tb

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+hdl
hdl/rv32_pkg.sv
hdl/rv32_regfile.sv
hdl/rv32_decode.sv
hdl/rv32_alu.sv
hdl/rv32_branch.sv
hdl/rv32_writeback.sv
hdl/rv32_execute.sv
hdl/rv32_core.sv
test/rv32_core_tb.sv

// ==== hdl/rv32_alu.sv ====
`include "rv32_macros.svh"

module rv32_alu (
    input  rv32_pkg::alu_op_t      op,
    input  logic                   sub_sra,
    input  rv32_pkg::src1_t        src1,
    input  rv32_pkg::src2_t        src2,
    input  logic [`RV32_XLEN-1:0]  pc,
    input  logic [`RV32_XLEN-1:0]  rs1_value,
    input  logic [`RV32_XLEN-1:0]  rs2_value,
    input  logic [`RV32_XLEN-1:0]  imm,
    output logic [`RV32_XLEN-1:0]  result
);
    logic [`RV32_XLEN-1:0] a;
    logic [`RV32_XLEN-1:0] b;
    logic [4:0]            shamt;

    always_comb begin
        case (src1)
            rv32_pkg::src1_rs1: a = rs1_value;
            rv32_pkg::src1_pc:  a = pc;
            default:            a = '0;
        endcase
        case (src2)
            rv32_pkg::src2_rs2: b = rs2_value;
            rv32_pkg::src2_imm: b = imm;
            default:            b = `RV32_XLEN'd4;
        endcase
    end

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv32_pkg::alu_add:  result = sub_sra ? a - b : a + b;
            rv32_pkg::alu_sll:  result = a << shamt;
            rv32_pkg::alu_slt:  result = {{(`RV32_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv32_pkg::alu_sltu: result = {{(`RV32_XLEN-1){1'b0}}, a < b};
            rv32_pkg::alu_xor:  result = a ^ b;
            rv32_pkg::alu_srl:  result = sub_sra ? $unsigned($signed(a) >>> shamt) : a >> shamt;
            rv32_pkg::alu_or:   result = a | b;
            default:            result = a & b;
        endcase
    end

endmodule

// ==== hdl/rv32_branch.sv ====
`include "rv32_macros.svh"

module rv32_branch (
    input  rv32_pkg::branch_op_t   op,
    input  rv32_pkg::pc_src_t      pc_src,
    input  logic [`RV32_XLEN-1:0]  pc,
    input  logic [`RV32_XLEN-1:0]  rs1_value,
    input  logic [`RV32_XLEN-1:0]  rs2_value,
    input  logic [`RV32_XLEN-1:0]  imm,
    output logic                   taken,
    output logic [`RV32_XLEN-1:0]  target
);
    logic                  eq;
    logic                  lt;
    logic                  ltu;
    logic [`RV32_XLEN-1:0] sum;

    assign eq  = rs1_value == rs2_value;
    assign lt  = $signed(rs1_value) < $signed(rs2_value);
    assign ltu = rs1_value < rs2_value;

    always_comb begin
        case (op)
            rv32_pkg::br_always: taken = 1'b1;
            rv32_pkg::br_eq:     taken = eq;
            rv32_pkg::br_ne:     taken = !eq;
            rv32_pkg::br_lt:     taken = lt;
            rv32_pkg::br_ge:     taken = !lt;
            rv32_pkg::br_ltu:    taken = ltu;
            rv32_pkg::br_geu:    taken = !ltu;
            default:             taken = 1'b0;
        endcase
    end

    assign sum    = ((pc_src == rv32_pkg::rs1_rel) ? rs1_value : pc) + imm;
    assign target = {sum[`RV32_XLEN-1:1], sum[0] && (pc_src == rv32_pkg::pc_rel)}; // JALR clears bit 0.

endmodule

// ==== hdl/rv32_core.sv ====
`include "rv32_macros.svh"

module rv32_core (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       valid,
    input  logic [`RV32_XLEN-1:0]      instr,
    input  logic [`RV32_XLEN-1:0]      pc,
    output logic                       retire_valid,
    output logic [`RV32_XLEN-1:0]      retire_pc,
    output logic [`RV32_REG_BITS-1:0]  retire_rd,
    output logic                       retire_rd_write,
    output logic [`RV32_XLEN-1:0]      retire_value,
    output logic                       retire_branch_taken,
    output logic [`RV32_XLEN-1:0]      retire_branch_target,
    output logic                       retire_illegal
);
    logic                      d_valid;
    logic [`RV32_XLEN-1:0]     d_pc;
    logic [`RV32_REG_BITS-1:0] d_rs1;
    logic [`RV32_REG_BITS-1:0] d_rs2;
    logic [`RV32_REG_BITS-1:0] d_rd;
    logic                      d_rd_write;
    rv32_pkg::alu_op_t         d_alu_op;
    logic                      d_sub_sra;
    rv32_pkg::src1_t           d_src1;
    rv32_pkg::src2_t           d_src2;
    logic [`RV32_XLEN-1:0]     d_imm;
    rv32_pkg::branch_op_t      d_branch_op;
    rv32_pkg::pc_src_t         d_pc_src;
    logic                      d_illegal;
    logic [`RV32_REG_BITS-1:0] rf_rs1_addr;
    logic [`RV32_REG_BITS-1:0] rf_rs2_addr;
    logic [`RV32_XLEN-1:0]     rf_rs1_data;
    logic [`RV32_XLEN-1:0]     rf_rs2_data;
    logic                      rf_wr_en;
    logic [`RV32_REG_BITS-1:0] rf_wr_addr;
    logic [`RV32_XLEN-1:0]     rf_wr_data;
    logic                      e_valid;
    logic [`RV32_XLEN-1:0]     e_pc;
    logic [`RV32_REG_BITS-1:0] e_rd;
    logic                      e_rd_write;
    logic [`RV32_XLEN-1:0]     e_result;
    logic                      e_branch_taken;
    logic [`RV32_XLEN-1:0]     e_branch_target;
    logic                      e_illegal;

    rv32_decode decode (
        .clk, .reset, .stall, .valid, .instr, .pc,
        .d_valid, .d_pc, .d_rs1, .d_rs2, .d_rd, .d_rd_write,
        .d_alu_op, .d_sub_sra, .d_src1, .d_src2, .d_imm,
        .d_branch_op, .d_pc_src, .d_illegal
    );

    rv32_regfile regfile (
        .clk,
        .rs1_addr (rf_rs1_addr),
        .rs2_addr (rf_rs2_addr),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .wr_en    (rf_wr_en),
        .wr_addr  (rf_wr_addr),
        .wr_data  (rf_wr_data)
    );

    rv32_execute execute (
        .clk, .reset, .stall,
        .d_valid, .d_pc, .d_rs1, .d_rs2, .d_rd, .d_rd_write,
        .d_alu_op, .d_sub_sra, .d_src1, .d_src2, .d_imm,
        .d_branch_op, .d_pc_src, .d_illegal,
        .rf_rs1_addr, .rf_rs2_addr, .rf_rs1_data, .rf_rs2_data,
        .e_valid, .e_pc, .e_rd, .e_rd_write, .e_result,
        .e_branch_taken, .e_branch_target, .e_illegal
    );

    rv32_writeback writeback (
        .clk, .reset, .stall,
        .e_valid, .e_pc, .e_rd, .e_rd_write, .e_result,
        .e_branch_taken, .e_branch_target, .e_illegal,
        .rf_wr_en, .rf_wr_addr, .rf_wr_data,
        .retire_valid, .retire_pc, .retire_rd, .retire_rd_write, .retire_value,
        .retire_branch_taken, .retire_branch_target, .retire_illegal
    );

endmodule

// ==== hdl/rv32_decode.sv ====
`include "rv32_macros.svh"

module rv32_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       valid,
    input  logic [`RV32_XLEN-1:0]      instr,
    input  logic [`RV32_XLEN-1:0]      pc,
    output logic                       d_valid,
    output logic [`RV32_XLEN-1:0]      d_pc,
    output logic [`RV32_REG_BITS-1:0]  d_rs1,
    output logic [`RV32_REG_BITS-1:0]  d_rs2,
    output logic [`RV32_REG_BITS-1:0]  d_rd,
    output logic                       d_rd_write,
    output rv32_pkg::alu_op_t          d_alu_op,
    output logic                       d_sub_sra,
    output rv32_pkg::src1_t            d_src1,
    output rv32_pkg::src2_t            d_src2,
    output logic [`RV32_XLEN-1:0]      d_imm,
    output rv32_pkg::branch_op_t       d_branch_op,
    output rv32_pkg::pc_src_t          d_pc_src,
    output logic                       d_illegal
);
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [`RV32_REG_BITS-1:0] rd;
    logic [`RV32_XLEN-1:0]     imm_i;
    logic [`RV32_XLEN-1:0]     imm_u;
    logic [`RV32_XLEN-1:0]     imm_b;
    logic [`RV32_XLEN-1:0]     imm_j;
    logic                      rd_write;
    rv32_pkg::alu_op_t         alu_op;
    logic                      sub_sra;
    rv32_pkg::src1_t           src1;
    rv32_pkg::src2_t           src2;
    logic [`RV32_XLEN-1:0]     imm;
    rv32_pkg::branch_op_t      branch_op;
    rv32_pkg::pc_src_t         pc_src;
    logic                      illegal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        rd_write  = 1'b0;
        alu_op    = rv32_pkg::alu_add;
        sub_sra   = 1'b0;
        src1      = rv32_pkg::src1_rs1;
        src2      = rv32_pkg::src2_imm;
        imm       = imm_i;
        branch_op = rv32_pkg::br_never;
        pc_src    = rv32_pkg::pc_rel;
        illegal   = 1'b0;
        case (opcode)
            7'b0110011: begin // OP.
                rd_write = 1'b1;
                alu_op   = rv32_pkg::alu_op_t'(funct3);
                sub_sra  = instr[30];
                src2     = rv32_pkg::src2_rs2;
            end
            7'b0010011: begin // OP-IMM where bit 30 only selects SRAI.
                rd_write = 1'b1;
                alu_op   = rv32_pkg::alu_op_t'(funct3);
                sub_sra  = (funct3 == 3'b101) && instr[30];
            end
            7'b0110111: begin // LUI.
                rd_write = 1'b1;
                src1     = rv32_pkg::src1_zero;
                imm      = imm_u;
            end
            7'b0010111: begin // AUIPC.
                rd_write = 1'b1;
                src1     = rv32_pkg::src1_pc;
                imm      = imm_u;
            end
            7'b1101111, 7'b1100111: begin // JAL and JALR link pc + 4.
                rd_write  = 1'b1;
                src1      = rv32_pkg::src1_pc;
                src2      = rv32_pkg::src2_four;
                imm       = opcode[3] ? imm_j : imm_i;
                branch_op = rv32_pkg::br_always;
                pc_src    = opcode[3] ? rv32_pkg::pc_rel : rv32_pkg::rs1_rel;
            end
            7'b1100011: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  branch_op = rv32_pkg::br_eq;
                    3'b001:  branch_op = rv32_pkg::br_ne;
                    3'b100:  branch_op = rv32_pkg::br_lt;
                    3'b101:  branch_op = rv32_pkg::br_ge;
                    3'b110:  branch_op = rv32_pkg::br_ltu;
                    3'b111:  branch_op = rv32_pkg::br_geu;
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            d_valid     <= valid;
            d_pc        <= pc;
            d_rs1       <= instr[19:15];
            d_rs2       <= instr[24:20];
            d_rd        <= rd;
            d_rd_write  <= valid && rd_write && (rd != '0);
            d_alu_op    <= alu_op;
            d_sub_sra   <= sub_sra;
            d_src1      <= src1;
            d_src2      <= src2;
            d_imm       <= imm;
            d_branch_op <= branch_op;
            d_pc_src    <= pc_src;
            d_illegal   <= valid && illegal;
        end
        if (reset) begin
            d_valid     <= 1'b0;
            d_rd_write  <= 1'b0;
            d_branch_op <= rv32_pkg::br_never;
            d_illegal   <= 1'b0;
        end
    end

endmodule

// ==== hdl/rv32_execute.sv ====
`include "rv32_macros.svh"

module rv32_execute (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       d_valid,
    input  logic [`RV32_XLEN-1:0]      d_pc,
    input  logic [`RV32_REG_BITS-1:0]  d_rs1,
    input  logic [`RV32_REG_BITS-1:0]  d_rs2,
    input  logic [`RV32_REG_BITS-1:0]  d_rd,
    input  logic                       d_rd_write,
    input  rv32_pkg::alu_op_t          d_alu_op,
    input  logic                       d_sub_sra,
    input  rv32_pkg::src1_t            d_src1,
    input  rv32_pkg::src2_t            d_src2,
    input  logic [`RV32_XLEN-1:0]      d_imm,
    input  rv32_pkg::branch_op_t       d_branch_op,
    input  rv32_pkg::pc_src_t          d_pc_src,
    input  logic                       d_illegal,
    output logic [`RV32_REG_BITS-1:0]  rf_rs1_addr,
    output logic [`RV32_REG_BITS-1:0]  rf_rs2_addr,
    input  logic [`RV32_XLEN-1:0]      rf_rs1_data,
    input  logic [`RV32_XLEN-1:0]      rf_rs2_data,
    output logic                       e_valid,
    output logic [`RV32_XLEN-1:0]      e_pc,
    output logic [`RV32_REG_BITS-1:0]  e_rd,
    output logic                       e_rd_write,
    output logic [`RV32_XLEN-1:0]      e_result,
    output logic                       e_branch_taken,
    output logic [`RV32_XLEN-1:0]      e_branch_target,
    output logic                       e_illegal
);
    logic                  fwd_valid;
    logic [`RV32_XLEN-1:0] rs1_value;
    logic [`RV32_XLEN-1:0] rs2_value;
    logic [`RV32_XLEN-1:0] alu_result;
    logic                  taken;
    logic [`RV32_XLEN-1:0] target;

    assign rf_rs1_addr = d_rs1;
    assign rf_rs2_addr = d_rs2;

    // The older instruction is already in the register file, so one bypass suffices.
    assign fwd_valid = e_valid && e_rd_write;
    assign rs1_value = (fwd_valid && e_rd == d_rs1 && d_rs1 != '0) ? e_result : rf_rs1_data;
    assign rs2_value = (fwd_valid && e_rd == d_rs2 && d_rs2 != '0) ? e_result : rf_rs2_data;

    rv32_alu alu (
        .op        (d_alu_op),
        .sub_sra   (d_sub_sra),
        .src1      (d_src1),
        .src2      (d_src2),
        .pc        (d_pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (d_imm),
        .result    (alu_result)
    );

    rv32_branch branch (
        .op        (d_branch_op),
        .pc_src    (d_pc_src),
        .pc        (d_pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (d_imm),
        .taken     (taken),
        .target    (target)
    );

    always_ff @(posedge clk) begin
        if (!stall) begin
            e_valid         <= d_valid;
            e_pc            <= d_pc;
            e_rd            <= d_rd;
            e_rd_write      <= d_rd_write;
            e_result        <= alu_result;
            e_branch_taken  <= d_valid && taken; // Bubbles never branch.
            e_branch_target <= target;
            e_illegal       <= d_illegal;
        end
        if (reset) begin
            e_valid        <= 1'b0;
            e_rd_write     <= 1'b0;
            e_branch_taken <= 1'b0;
            e_illegal      <= 1'b0;
        end
    end

endmodule

// ==== hdl/rv32_macros.svh ====
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

`define RV32_XLEN 32 // Data and address width.
`define RV32_REG_BITS 5 // Register address width.

`endif

// ==== hdl/rv32_pkg.sv ====
package rv32_pkg;

    // Encodings follow funct3 so OP and OP-IMM map straight through.
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        src1_rs1  = 2'b00,
        src1_pc   = 2'b01,
        src1_zero = 2'b10 // LUI.
    } src1_t;

    typedef enum logic [1:0] {
        src2_rs2  = 2'b00,
        src2_imm  = 2'b01,
        src2_four = 2'b10 // Link value.
    } src2_t;

    typedef enum logic [2:0] {
        br_never  = 3'b000,
        br_always = 3'b001,
        br_eq     = 3'b010,
        br_ne     = 3'b011,
        br_lt     = 3'b100,
        br_ge     = 3'b101,
        br_ltu    = 3'b110,
        br_geu    = 3'b111
    } branch_op_t;

    typedef enum logic {
        pc_rel  = 1'b0,
        rs1_rel = 1'b1 // JALR.
    } pc_src_t;

endpackage

// ==== hdl/rv32_regfile.sv ====
`include "rv32_macros.svh"

module rv32_regfile (
    input  logic                      clk,
    input  logic [`RV32_REG_BITS-1:0] rs1_addr,
    input  logic [`RV32_REG_BITS-1:0] rs2_addr,
    output logic [`RV32_XLEN-1:0]     rs1_data,
    output logic [`RV32_XLEN-1:0]     rs2_data,
    input  logic                      wr_en,
    input  logic [`RV32_REG_BITS-1:0] wr_addr,
    input  logic [`RV32_XLEN-1:0]     wr_data
);
    logic [`RV32_XLEN-1:0] regs [1:31];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin // x0 stays zero.
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== hdl/rv32_writeback.sv ====
`include "rv32_macros.svh"

module rv32_writeback (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       e_valid,
    input  logic [`RV32_XLEN-1:0]      e_pc,
    input  logic [`RV32_REG_BITS-1:0]  e_rd,
    input  logic                       e_rd_write,
    input  logic [`RV32_XLEN-1:0]      e_result,
    input  logic                       e_branch_taken,
    input  logic [`RV32_XLEN-1:0]      e_branch_target,
    input  logic                       e_illegal,
    output logic                       rf_wr_en,
    output logic [`RV32_REG_BITS-1:0]  rf_wr_addr,
    output logic [`RV32_XLEN-1:0]      rf_wr_data,
    output logic                       retire_valid,
    output logic [`RV32_XLEN-1:0]      retire_pc,
    output logic [`RV32_REG_BITS-1:0]  retire_rd,
    output logic                       retire_rd_write,
    output logic [`RV32_XLEN-1:0]      retire_value,
    output logic                       retire_branch_taken,
    output logic [`RV32_XLEN-1:0]      retire_branch_target,
    output logic                       retire_illegal
);
    // Write lands on the edge the instruction leaves execute.
    assign rf_wr_en   = !stall && e_valid && e_rd_write;
    assign rf_wr_addr = e_rd;
    assign rf_wr_data = e_result;

    always_ff @(posedge clk) begin
        if (!stall) begin
            retire_valid         <= e_valid;
            retire_pc            <= e_pc;
            retire_rd            <= e_rd;
            retire_rd_write      <= e_rd_write;
            retire_value         <= e_result;
            retire_branch_taken  <= e_branch_taken;
            retire_branch_target <= e_branch_target;
            retire_illegal       <= e_illegal;
        end else begin
            retire_valid        <= 1'b0; // Bubble.
            retire_rd_write     <= 1'b0;
            retire_branch_taken <= 1'b0;
            retire_illegal      <= 1'b0;
        end
        if (reset) begin
            retire_valid        <= 1'b0;
            retire_rd_write     <= 1'b0;
            retire_branch_taken <= 1'b0;
            retire_illegal      <= 1'b0;
        end
    end

endmodule

// ==== test/rv32_core_tb.sv ====
`include "rv32_macros.svh"

module rv32_core_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 600;
    localparam int N_INSTR      = N_RANDOM + 7; // Random stream plus register preamble.

    typedef struct packed {
        logic [`RV32_XLEN-1:0]     pc;
        logic [`RV32_REG_BITS-1:0] rd;
        logic                      rd_write;
        logic [`RV32_XLEN-1:0]     value;
        logic                      taken;
        logic                      has_target;
        logic [`RV32_XLEN-1:0]     target;
        logic                      illegal;
        logic [31:0]               go_index;
    } expect_t;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      stall;
    logic                      valid;
    logic [`RV32_XLEN-1:0]     instr;
    logic [`RV32_XLEN-1:0]     pc;
    logic                      retire_valid;
    logic [`RV32_XLEN-1:0]     retire_pc;
    logic [`RV32_REG_BITS-1:0] retire_rd;
    logic                      retire_rd_write;
    logic [`RV32_XLEN-1:0]     retire_value;
    logic                      retire_branch_taken;
    logic [`RV32_XLEN-1:0]     retire_branch_target;
    logic                      retire_illegal;

    logic [`RV32_XLEN-1:0] model_regs [0:31];
    expect_t               exp_q [$];
    int unsigned           go_count = 0; // Edges with stall low.
    logic [`RV32_XLEN-1:0] pc_next  = 32'h0000_1000;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv32_core DUT (
        .clk, .reset, .stall, .valid, .instr, .pc,
        .retire_valid, .retire_pc, .retire_rd, .retire_rd_write, .retire_value,
        .retire_branch_taken, .retire_branch_target, .retire_illegal
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // ISA semantics on the model register file in program order.
    function automatic expect_t expected_result(input logic [31:0] word, input logic [31:0] at_pc);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] v;
        logic [4:0]  sh;
        logic        wr;
        e     = '0;
        v     = '0;
        wr    = 1'b0;
        a     = model_regs[word[19:15]];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        b     = word[5] ? model_regs[word[24:20]] : imm_i; // Register operand only for OP.
        sh    = b[4:0];
        case (word[6:0])
            7'b0110011, 7'b0010011: begin
                wr = 1'b1;
                case (word[14:12])
                    3'd0: begin
                        if (word[5] && word[30]) v = a - b;
                        else v = a + b;
                    end
                    3'd1: v = a << sh;
                    3'd2: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd3: v = (a < b) ? 32'd1 : 32'd0;
                    3'd4: v = a ^ b;
                    3'd5: begin
                        if (word[30]) v = $signed(a) >>> sh;
                        else v = a >> sh;
                    end
                    3'd6: v = a | b;
                    default: v = a & b;
                endcase
            end
            7'b0110111: begin
                wr = 1'b1;
                v  = {word[31:12], 12'b0};
            end
            7'b0010111: begin
                wr = 1'b1;
                v  = at_pc + {word[31:12], 12'b0};
            end
            7'b1101111, 7'b1100111: begin // JAL and JALR.
                wr           = 1'b1;
                v            = at_pc + 32'd4;
                e.taken      = 1'b1;
                e.has_target = 1'b1;
                e.target     = word[3] ? at_pc + imm_j : (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                b            = model_regs[word[24:20]];
                e.has_target = 1'b1;
                e.target     = at_pc + imm_b;
                case (word[14:12])
                    3'd0: e.taken = (a == b);
                    3'd1: e.taken = (a != b);
                    3'd4: e.taken = ($signed(a) < $signed(b));
                    3'd5: e.taken = ($signed(a) >= $signed(b));
                    3'd6: e.taken = (a < b);
                    3'd7: e.taken = (a >= b);
                    default: e.illegal = 1'b1;
                endcase
            end
            default: e.illegal = 1'b1;
        endcase
        e.pc       = at_pc;
        e.rd       = word[11:7];
        e.rd_write = wr && (word[11:7] != 5'd0);
        e.value    = v;
        if (e.rd_write) model_regs[word[11:7]] = v;
        return e;
    endfunction

    // Random RV32I encoding using registers x0 to x7.
    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] r;
        int unsigned kind;
        logic [6:0]  bad_ops [4];
        bad_ops = '{7'b0000011, 7'b0100011, 7'b1110011, 7'b0001111};
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        f3   = 3'($urandom_range(0, 7));
        r    = $urandom();
        f7   = ($urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0000000;
        kind = $urandom_range(0, 19);
        if (kind < 6) begin
            if (f3 != 3'd0 && f3 != 3'd5) f7 = '0;
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind < 11) begin
            if (f3 == 3'd1) return {7'b0, r[4:0], rs1, f3, rd, 7'b0010011};
            if (f3 == 3'd5) return {f7, r[4:0], rs1, f3, rd, 7'b0010011};
            return {r[11:0], rs1, f3, rd, 7'b0010011};
        end else if (kind == 11) begin
            return {r[19:0], rd, 7'b0110111};
        end else if (kind == 12) begin
            return {r[19:0], rd, 7'b0010111};
        end else if (kind == 13) begin
            return {r[19:0], rd, 7'b1101111};
        end else if (kind == 14) begin
            return {r[11:0], rs1, 3'b000, rd, 7'b1100111};
        end else if (kind < 19) begin
            f3 = 3'($urandom_range(0, 5));
            if (f3 > 3'd1) f3 = f3 + 3'd2; // Skip the two reserved encodings.
            return {r[6:0], rs2, rs1, f3, r[11:7], 7'b1100011};
        end
        return {r[24:0], bad_ops[$urandom_range(0, 3)]};
    endfunction

    task automatic idle_cycle(input logic may_stall);
        @(negedge clk);
        valid = 1'b0;
        instr = $urandom();
        stall = may_stall && ($urandom_range(0, 3) == 0);
        @(posedge clk);
        if (!stall) go_count++;
    endtask

    // Holds the word until an edge with stall low takes it.
    task automatic offer(input logic [31:0] word, input logic may_stall);
        expect_t e;
        logic    accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            valid = 1'b1;
            instr = word;
            pc    = pc_next;
            stall = may_stall && ($urandom_range(0, 3) == 0);
            @(posedge clk);
            if (!stall) begin
                go_count++;
                accepted   = 1'b1;
                e          = expected_result(word, pc_next);
                e.go_index = go_count;
                exp_q.push_back(e);
                pc_next    = pc_next + 32'd4;
            end
        end
    endtask

    initial begin
        int unsigned i;
        void'($urandom(32'h7bf4a452));
        reset = 1'b1;
        stall = 1'b0;
        valid = 1'b0;
        instr = '0;
        pc    = '0;
        for (i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) idle_cycle(1'b0);
        for (i = 1; i < 8; i++) begin
            offer({20'($urandom()), 5'(i), 7'b0110111}, 1'b0); // LUI seeds x1 to x7.
        end
        for (i = 0; i < N_RANDOM; i++) begin
            if ($urandom_range(0, 7) == 0) idle_cycle(1'b1);
            offer(random_instr(), 1'b1);
        end
        repeat (2) idle_cycle(1'b0); // Last accepted instruction reaches retire.
        repeat (4) idle_cycle(1'b0); // Catch any stray retire.
        if (exp_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "Instructions were left without a retire.");
        end
    end

    // Comparer samples away from the active edge.
    always @(negedge clk) begin
        expect_t e;
        if (retire_valid !== 1'b0) begin
            assert (exp_q.size() != 0) else begin
                abort_run("A retire appeared with no accepted instruction outstanding.");
            end
            e = exp_q.pop_front();
            assert (go_count == e.go_index + 2) else begin
                abort_run($sformatf("Instruction at pc %h retired at the wrong cycle.", e.pc));
            end
            check_value("retire_pc", retire_pc, e.pc);
            check_value("retire_illegal", 32'(retire_illegal), 32'(e.illegal));
            check_value("retire_rd_write", 32'(retire_rd_write), 32'(e.rd_write));
            check_value("retire_branch_taken", 32'(retire_branch_taken), 32'(e.taken));
            if (e.has_target) check_value("retire_branch_target", retire_branch_target, e.target);
            if (e.rd_write) begin
                check_value("retire_rd", 32'(retire_rd), 32'(e.rd));
                check_value("retire_value", retire_value, e.value);
            end
        end
    end

    initial begin
        #((N_INSTR * 4 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the core stopped retiring instructions.");
        $display("** FAIL **");
        $fatal(1, "Watchdog expired.");
    end

endmodule
